//--- gpif_pkg.sv
/*
 * Shared definitions for the slave FIFO bus master
 * Endpoint addresses, FIFO depths, settle count and FSM states
 */
package gpif_pkg;

   ////////////////////////////////
   // Endpoint addresses, FPGA view
   ////////////////////////////////
   localparam logic [1:0] ADDR_DATA_TX = 2'd0;  // Host data into FPGA
   localparam logic [1:0] ADDR_DATA_RX = 2'd1;  // FPGA data to host
   localparam logic [1:0] ADDR_CTRL_TX = 2'd2;  // Host control into FPGA
   localparam logic [1:0] ADDR_CTRL_RX = 2'd3;  // Responses to host

   // Local FIFO sizes in 32-bit words
   localparam int DATA_FIFO_DEPTH = 512;        // Room for a full data packet
   localparam int CTRL_FIFO_DEPTH = 32;         // Control packets stay small

   // Free words kept back for the read pipeline still in flight
   localparam int NEARLY_FULL_MARGIN = 8;

   // Ready cycles needed at one address before deciding
   localparam int SETTLE_CYCLES = 8;

   ////////////////////////////////
   // Bus master FSM
   ////////////////////////////////
   typedef enum logic [2:0] {
      ST_IDLE,    // Load next address
      ST_WAIT,    // Let the flags settle
      ST_THINK,   // Pick read, write or neither
      ST_READ,    // Burst from controller
      ST_WRITE    // Burst to controller
   } gpif_state_t;

endpackage

//--- gpif_stream_if.sv
/*
 * One 32-bit packet stream with valid/ready handshake
 */
interface gpif_stream_if;

   logic [31:0] tdata;   // Payload word
   logic        tlast;   // Final word of a packet
   logic        tvalid;  // Source has a word
   logic        tready;  // Sink takes the word

   // Driving side
   modport src (output tdata, output tlast, output tvalid, input tready);

   // Receiving side
   modport snk (input tdata, input tlast, input tvalid, output tready);

endinterface

//--- gpif_stream_fifo.sv
/*
 * Synchronous packet FIFO, data word plus last bit
 * Registered has-space and nearly-full flags
 */
module gpif_stream_fifo
   import gpif_pkg::*;
#(
   parameter int DEPTH = 32                  // Words, power of two
) (
   input  logic          gpif_clk,
   input  logic          gpif_rst,
   gpif_stream_if.snk    i_in,               // Write side
   gpif_stream_if.src    i_out,              // Read side
   output logic          o_has_space,        // At least one word free
   output logic          o_nearly_full       // Fewer than margin words free
);

   logic [32:0]                  mem [DEPTH]; // {last, data}
   logic [$clog2(DEPTH)-1:0]     wr_ptr;
   logic [$clog2(DEPTH)-1:0]     rd_ptr;
   logic [$clog2(DEPTH+1)-1:0]   count;
   logic [$clog2(DEPTH+1)-1:0]   count_nxt;
   logic                         push;
   logic                         pop;

   assign i_in.tready  = (count != $bits(count)'(DEPTH));  // Not full
   assign i_out.tvalid = (count != '0);
   assign {i_out.tlast, i_out.tdata} = mem[rd_ptr];        // Head of queue

   assign push = i_in.tvalid && i_in.tready;
   assign pop  = i_out.tvalid && i_out.tready;

   // Occupancy after this edge
   assign count_nxt = count + $bits(count)'(push) - $bits(count)'(pop);

   ////////////////////////////////
   // Storage
   ////////////////////////////////
   always_ff @(posedge gpif_clk) begin
      if (push) begin
         mem[wr_ptr] <= {i_in.tlast, i_in.tdata};
      end
   end

   ////////////////////////////////
   // Pointers, count and flags
   ////////////////////////////////
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         wr_ptr        <= '0;
         rd_ptr        <= '0;
         count         <= '0;
         o_has_space   <= 1'b1;
         o_nearly_full <= 1'b0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;   // Wraps at DEPTH
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
         count <= count_nxt;
         // Flags follow the new count so they line up with it
         o_has_space   <= (count_nxt < $bits(count)'(DEPTH));
         o_nearly_full <= (count_nxt > $bits(count)'(DEPTH - NEARLY_FULL_MARGIN));
      end
   end

endmodule

//--- gpif_addr_arbiter.sv
/*
 * Next endpoint address by readiness and fairness
 * Per-address readiness, read/write go and nearly-full flags
 */
module gpif_addr_arbiter
   import gpif_pkg::*;
(
   input  logic       gpif_clk,
   input  logic       gpif_rst,
   input  logic [1:0] i_fifoadr,              // Address under test
   input  logic [1:0] i_last_addr,            // Address served last
   input  logic       i_ctrl_rx_valid,        // Response words waiting
   input  logic       i_data_rx_valid,        // Data words waiting
   input  logic       i_ctrl_tx_space,
   input  logic       i_data_tx_space,
   input  logic       i_ctrl_tx_nearly_full,
   input  logic       i_data_tx_nearly_full,
   output logic [1:0] o_next_addr,
   output logic       o_local_ready,
   output logic       o_read_go,
   output logic       o_write_go,
   output logic       o_nearly_full
);

   logic       at_data_tx, at_data_rx, at_ctrl_tx, at_ctrl_rx;
   logic [1:0] pick;

   assign at_data_tx = (i_fifoadr == ADDR_DATA_TX);
   assign at_data_rx = (i_fifoadr == ADDR_DATA_RX);
   assign at_ctrl_tx = (i_fifoadr == ADDR_CTRL_TX);
   assign at_ctrl_rx = (i_fifoadr == ADDR_CTRL_RX);

   // Fixed priority, skipping whoever went last
   always_comb begin
      if (i_ctrl_rx_valid && i_last_addr != ADDR_CTRL_RX)      pick = ADDR_CTRL_RX;
      else if (i_ctrl_tx_space && i_last_addr != ADDR_CTRL_TX) pick = ADDR_CTRL_TX;
      else if (i_data_rx_valid && i_last_addr != ADDR_DATA_RX) pick = ADDR_DATA_RX;
      else if (i_data_tx_space && i_last_addr != ADDR_DATA_TX) pick = ADDR_DATA_TX;
      else                                                     pick = i_fifoadr + 2'd1;
   end

   // Local side can take part at this address
   assign o_local_ready = (i_ctrl_rx_valid && at_ctrl_rx) || (i_ctrl_tx_space && at_ctrl_tx) ||
                          (i_data_rx_valid && at_data_rx) || (i_data_tx_space && at_data_tx);

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         o_next_addr   <= ADDR_DATA_TX;
         o_read_go     <= 1'b0;
         o_write_go    <= 1'b0;
         o_nearly_full <= 1'b0;
      end else begin
         o_next_addr   <= pick;
         o_read_go     <= (i_ctrl_tx_space && at_ctrl_tx) || (i_data_tx_space && at_data_tx);
         o_write_go    <= (i_ctrl_rx_valid && at_ctrl_rx) || (i_data_rx_valid && at_data_rx);
         o_nearly_full <= (i_ctrl_tx_nearly_full && at_ctrl_tx) ||
                          (i_data_tx_nearly_full && at_data_tx);  // Stops a read burst
      end
   end

endmodule

//--- gpif_bus_master.sv
/*
 * Slave FIFO bus master FSM
 * Bus strobes, read-valid delay line, write data register
 */
module gpif_bus_master
   import gpif_pkg::*;
(
   input  logic        gpif_clk,
   input  logic        gpif_rst,
   input  logic        i_enb,            // Clock enable for the FSM
   input  logic        i_ep_ready,       // Synchronized flag bit 0
   input  logic        i_ep_wmark,       // Synchronized flag bit 1
   input  logic [1:0]  i_next_addr,
   input  logic        i_local_ready,
   input  logic        i_read_go,
   input  logic        i_write_go,
   input  logic        i_nearly_full,
   gpif_stream_if.snk  egress,           // Selected rx word
   output logic        o_rd_valid,       // Registered bus word is good
   output logic        o_rd_last,
   output logic        o_sloe,
   output logic        o_slrd,
   output logic        o_slwr,
   output logic        o_pktend,
   output logic [1:0]  o_fifoadr,
   output logic [1:0]  o_last_addr,
   output logic [31:0] o_data_out
);

   gpif_state_t                      state;
   logic [$clog2(SETTLE_CYCLES)-1:0] settle_cnt;
   logic [2:0]                       slrd_d;     // slrd delayed 1, 2, 3 cycles
   logic                             rd_one;     // Read pipeline has produced a word
   logic                             wr_one;     // First write already allowed
   logic                             rd_pipe;    // Word arriving from the bus
   logic                             wr_valid;
   logic                             wr_xfer;
   logic                             wr_eof;

   ////////////////////////////////
   // Read pipeline
   ////////////////////////////////
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         slrd_d <= 3'b111;
      end else begin
         slrd_d <= {slrd_d[1:0], o_slrd};
      end
   end

   assign rd_pipe    = ~slrd_d[2];                    // Controller latency plus input reg
   assign o_rd_valid = (state == ST_READ) && rd_pipe;
   assign o_rd_last  = slrd_d[1];                     // slrd rose a cycle earlier

   // First write goes out before the watermark is trusted
   assign wr_valid     = i_ep_wmark || !wr_one;
   assign egress.tready = (state == ST_WRITE) && wr_valid;
   assign wr_xfer      = egress.tvalid && egress.tready;
   assign wr_eof       = wr_xfer && egress.tlast;

   ////////////////////////////////
   // Bus FSM
   ////////////////////////////////
   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         state       <= ST_IDLE;
         o_sloe      <= 1'b0;
         o_slrd      <= 1'b1;
         o_slwr      <= 1'b1;
         o_pktend    <= 1'b1;
         o_fifoadr   <= ADDR_DATA_TX;
         o_last_addr <= ADDR_DATA_TX;
         settle_cnt  <= '0;
         rd_one      <= 1'b0;
         wr_one      <= 1'b0;
      end else if (i_enb) begin
         case (state)
            ST_IDLE: begin
               o_sloe     <= 1'b0;             // Release the bus
               o_slrd     <= 1'b1;
               o_slwr     <= 1'b1;
               o_pktend   <= 1'b1;
               o_fifoadr  <= i_next_addr;
               settle_cnt <= '0;
               state      <= ST_WAIT;
            end

            // Need an unbroken run of ready cycles, else try the next address
            ST_WAIT: begin
               if (i_local_ready) begin
                  settle_cnt <= settle_cnt + 1'b1;
                  if (settle_cnt == $bits(settle_cnt)'(SETTLE_CYCLES - 1)) begin
                     state <= ST_THINK;
                  end
               end else begin
                  settle_cnt <= '0;
                  o_fifoadr  <= o_fifoadr + 2'd1;
               end
            end

            ST_THINK: begin
               if (i_ep_ready && i_read_go) begin
                  state  <= ST_READ;
                  o_slrd <= 1'b0;              // Start the read burst
                  rd_one <= 1'b0;
               end else if (i_ep_ready && i_write_go) begin
                  state  <= ST_WRITE;
                  o_sloe <= 1'b1;              // FPGA takes the bus
                  wr_one <= 1'b0;
               end else begin
                  state <= ST_IDLE;
               end
               settle_cnt  <= '0;
               o_last_addr <= o_fifoadr;       // Fairness memory
            end

            ST_READ: begin
               if (rd_one && !rd_pipe) state <= ST_IDLE;        // Pipeline drained
               if (!i_ep_wmark || i_nearly_full) o_slrd <= 1'b1;
               if (rd_pipe) rd_one <= 1'b1;
            end

            ST_WRITE: begin
               if (!wr_xfer || wr_eof) state <= ST_IDLE;        // Empty or packet done
               o_slwr   <= ~wr_xfer;
               o_pktend <= ~wr_eof;
               if (wr_valid) wr_one <= 1'b1;
            end

            default: state <= ST_IDLE;
         endcase
      end
   end

   // Word for the bus, captured as it leaves the egress FIFO
   always_ff @(posedge gpif_clk) begin
      if (i_enb && state == ST_WRITE) begin
         o_data_out <= egress.tdata;
      end
   end

endmodule

//--- gpif_slave_fifo32.sv
/*
 * Slave FIFO bus master top level
 * Bus tristate, input and flag registers, stream FIFOs, endpoint steering
 */
module gpif_slave_fifo32
   import gpif_pkg::*;
(
   input  logic        gpif_clk,
   input  logic        gpif_rst,
   input  logic        i_gpif_enb,
   inout  wire  [31:0] io_gpif_d,
   input  logic [3:0]  i_gpif_ctl,
   output logic        o_sloe,
   output logic        o_slrd,
   output logic        o_slwr,
   output logic        o_pktend,
   output logic [1:0]  o_fifoadr,
   output logic [31:0] o_tx_tdata,
   output logic        o_tx_tlast,
   output logic        o_tx_tvalid,
   input  logic        i_tx_tready,
   output logic [31:0] o_ctrl_tdata,
   output logic        o_ctrl_tlast,
   output logic        o_ctrl_tvalid,
   input  logic        i_ctrl_tready,
   input  logic [31:0] i_rx_tdata,
   input  logic        i_rx_tlast,
   input  logic        i_rx_tvalid,
   output logic        o_rx_tready,
   input  logic [31:0] i_resp_tdata,
   input  logic        i_resp_tlast,
   input  logic        i_resp_tvalid,
   output logic        o_resp_tready
);

   logic [31:0] data_in, data_out;
   logic [1:0]  ready_s, wmark_s;               // Two-stage flag registers
   logic [1:0]  next_addr, last_addr;
   logic        rd_valid, rd_last, local_ready, read_go, write_go, nearly_full;
   logic        tx_space, ctrl_space, tx_nfull, ctrl_nfull;

   gpif_stream_if tx_in (), tx_out (), ctrl_in (), ctrl_out ();
   gpif_stream_if rx_in (), rx_out (), resp_in (), resp_out (), egress ();

   ////////////////////////////////
   // Pins
   ////////////////////////////////
   assign io_gpif_d = o_sloe ? data_out : 'z;   // Drive only while writing

   always_ff @(posedge gpif_clk) data_in <= io_gpif_d;

   always_ff @(posedge gpif_clk) begin
      if (gpif_rst) begin
         ready_s <= '0;
         wmark_s <= '0;
      end else begin
         ready_s <= {ready_s[0], i_gpif_ctl[0]};
         wmark_s <= {wmark_s[0], i_gpif_ctl[1]};
      end
   end

   ////////////////////////////////
   // Bus side steering
   ////////////////////////////////
   assign tx_in.tdata    = data_in;
   assign tx_in.tlast    = rd_last;
   assign tx_in.tvalid   = rd_valid && (o_fifoadr == ADDR_DATA_TX);
   assign ctrl_in.tdata  = data_in;
   assign ctrl_in.tlast  = rd_last;
   assign ctrl_in.tvalid = rd_valid && (o_fifoadr == ADDR_CTRL_TX);

   // Egress FIFO at the current address feeds the master
   assign egress.tdata    = (o_fifoadr == ADDR_CTRL_RX) ? resp_out.tdata  : rx_out.tdata;
   assign egress.tlast    = (o_fifoadr == ADDR_CTRL_RX) ? resp_out.tlast  : rx_out.tlast;
   assign egress.tvalid   = (o_fifoadr == ADDR_CTRL_RX) ? resp_out.tvalid : rx_out.tvalid;
   assign rx_out.tready   = egress.tready && (o_fifoadr == ADDR_DATA_RX);
   assign resp_out.tready = egress.tready && (o_fifoadr == ADDR_CTRL_RX);

   ////////////////////////////////
   // Stream side ports
   ////////////////////////////////
   assign {o_tx_tdata, o_tx_tlast, o_tx_tvalid}       = {tx_out.tdata, tx_out.tlast, tx_out.tvalid};
   assign tx_out.tready                               = i_tx_tready;
   assign {o_ctrl_tdata, o_ctrl_tlast, o_ctrl_tvalid} = {ctrl_out.tdata, ctrl_out.tlast,
                                                         ctrl_out.tvalid};
   assign ctrl_out.tready                             = i_ctrl_tready;
   assign {rx_in.tdata, rx_in.tlast, rx_in.tvalid}    = {i_rx_tdata, i_rx_tlast, i_rx_tvalid};
   assign o_rx_tready                                 = rx_in.tready;
   assign {resp_in.tdata, resp_in.tlast, resp_in.tvalid} = {i_resp_tdata, i_resp_tlast,
                                                            i_resp_tvalid};
   assign o_resp_tready                               = resp_in.tready;

   gpif_bus_master master_i (
      .gpif_clk, .gpif_rst, .i_enb(i_gpif_enb),
      .i_ep_ready(ready_s[1]), .i_ep_wmark(wmark_s[1]), .i_next_addr(next_addr),
      .i_local_ready(local_ready), .i_read_go(read_go), .i_write_go(write_go),
      .i_nearly_full(nearly_full), .egress(egress),
      .o_rd_valid(rd_valid), .o_rd_last(rd_last), .o_sloe, .o_slrd, .o_slwr, .o_pktend,
      .o_fifoadr, .o_last_addr(last_addr), .o_data_out(data_out)
   );

   gpif_addr_arbiter arb_i (
      .gpif_clk, .gpif_rst, .i_fifoadr(o_fifoadr), .i_last_addr(last_addr),
      .i_ctrl_rx_valid(resp_out.tvalid), .i_data_rx_valid(rx_out.tvalid),
      .i_ctrl_tx_space(ctrl_space), .i_data_tx_space(tx_space),
      .i_ctrl_tx_nearly_full(ctrl_nfull), .i_data_tx_nearly_full(tx_nfull),
      .o_next_addr(next_addr), .o_local_ready(local_ready), .o_read_go(read_go),
      .o_write_go(write_go), .o_nearly_full(nearly_full)
   );

   // Ingress, filled from the bus
   gpif_stream_fifo #(.DEPTH(DATA_FIFO_DEPTH)) tx_fifo_i (
      .gpif_clk, .gpif_rst, .i_in(tx_in), .i_out(tx_out),
      .o_has_space(tx_space), .o_nearly_full(tx_nfull)
   );
   gpif_stream_fifo #(.DEPTH(CTRL_FIFO_DEPTH)) ctrl_fifo_i (
      .gpif_clk, .gpif_rst, .i_in(ctrl_in), .i_out(ctrl_out),
      .o_has_space(ctrl_space), .o_nearly_full(ctrl_nfull)
   );

   // Egress, drained to the bus
   gpif_stream_fifo #(.DEPTH(DATA_FIFO_DEPTH)) rx_fifo_i (
      .gpif_clk, .gpif_rst, .i_in(rx_in), .i_out(rx_out),
      .o_has_space(), .o_nearly_full()
   );
   gpif_stream_fifo #(.DEPTH(CTRL_FIFO_DEPTH)) resp_fifo_i (
      .gpif_clk, .gpif_rst, .i_in(resp_in), .i_out(resp_out),
      .o_has_space(), .o_nearly_full()
   );

endmodule

//--- fx3_slave_model.sv
/*
 * Controller model in slave FIFO mode
 * Host queues at addresses 0 and 2, capture at 1 and 3, flags and bus drive
 */
module fx3_slave_model
   import gpif_pkg::*;
(
   input  logic        gpif_clk,
   inout  wire  [31:0] io_gpif_d,
   input  logic        i_sloe,
   input  logic        i_slrd,
   input  logic        i_slwr,
   input  logic        i_pktend,
   input  logic [1:0]  i_fifoadr,
   output logic [3:0]  o_ctl          // {unused, unused, watermark, ready}
);

   // Flag drops at this many words so the reads still in flight end the packet
   localparam int WMARK_LEVEL = 3;

   logic [32:0] data_q [$];           // Address 0, {last, word}
   logic [32:0] ctrl_q [$];           // Address 2
   logic [31:0] p1;                   // First read latency stage
   logic [31:0] bus_q;                // Word on the bus
   logic        s_rd, s_wr, s_end;
   logic [1:0]  s_adr;
   int          pkt_cnt [4];          // Packets closed by pktend

   assign io_gpif_d = i_sloe ? 'z : bus_q;   // FPGA owns the bus while sloe high

   task automatic push_host(input logic [1:0] adr, input logic [32:0] w);
      if (adr == ADDR_DATA_TX) data_q.push_back(w);
      else ctrl_q.push_back(w);
   endtask

   // Words left in the packet at the head of a queue
   function automatic int left_in_pkt(input logic [32:0] q [$]);
      int n;
      n = 0;
      for (int i = 0; i < q.size(); i++) begin
         n++;
         if (q[i][32]) break;
      end
      return n;
   endfunction

   initial begin
      p1 = '0;
      bus_q = '0;
      o_ctl = '0;
      {s_rd, s_wr, s_end, s_adr} = '0;
      for (int i = 0; i < 4; i++) begin
         pkt_cnt[i] = 0;
      end
   end

   // Strobes are stable mid cycle
   always @(negedge gpif_clk) begin
      s_rd  = !i_slrd;
      s_wr  = !i_slwr;
      s_end = !i_pktend;
      s_adr = i_fifoadr;
   end

   always @(posedge gpif_clk) begin : ctl_update
      logic [32:0] w;
      #2;
      bus_q = p1;                     // Second latency stage
      if (s_rd && s_adr == ADDR_DATA_TX && data_q.size() > 0) begin
         w = data_q.pop_front();
         p1 = w[31:0];
      end else if (s_rd && s_adr == ADDR_CTRL_TX && ctrl_q.size() > 0) begin
         w = ctrl_q.pop_front();
         p1 = w[31:0];
      end
      if (s_wr && s_end) pkt_cnt[s_adr]++;
      ////////////////////////////////
      // Flags for the current address
      case (i_fifoadr)
         ADDR_DATA_TX: o_ctl = {2'b00, left_in_pkt(data_q) > WMARK_LEVEL, data_q.size() > 0};
         ADDR_CTRL_TX: o_ctl = {2'b00, left_in_pkt(ctrl_q) > WMARK_LEVEL, ctrl_q.size() > 0};
         default:      o_ctl = 4'b0011;    // Capture side always has room
      endcase
   end

endmodule

//--- tb_gpif_slave_fifo32.sv
/*
 * Testbench for the slave FIFO bus master
 * Clock, reset, LFSR stimulus, reference packets, compare, watchdog, report
 */
module tb_gpif_slave_fifo32 import gpif_pkg::*; ();

   localparam int MAX_WORDS = 480;            // Upper bound over all tests

   logic        gpif_clk, gpif_rst, gpif_enb;
   wire  [31:0] gpif_d;
   logic [3:0]  gpif_ctl;
   logic        sloe, slrd, slwr, pktend;
   logic [1:0]  fifoadr;
   logic [31:0] tx_tdata, ctrl_tdata, rx_tdata, resp_tdata;
   logic        tx_tlast, tx_tvalid, tx_tready, ctrl_tlast, ctrl_tvalid, ctrl_tready;
   logic        rx_tlast, rx_tvalid, rx_tready, resp_tlast, resp_tvalid, resp_tready;
   logic [31:0] lfsr_state;
   logic        rand_tready;
   int          errors, checks, tx_pkts, ctrl_pkts;
   logic [32:0] exp_tx [$], exp_ctrl [$], exp_cap1 [$], exp_cap3 [$];

   gpif_slave_fifo32 dut_i (
      .gpif_clk, .gpif_rst, .i_gpif_enb(gpif_enb), .io_gpif_d(gpif_d), .i_gpif_ctl(gpif_ctl),
      .o_sloe(sloe), .o_slrd(slrd), .o_slwr(slwr), .o_pktend(pktend), .o_fifoadr(fifoadr),
      .o_tx_tdata(tx_tdata), .o_tx_tlast(tx_tlast), .o_tx_tvalid(tx_tvalid),
      .i_tx_tready(tx_tready), .o_ctrl_tdata(ctrl_tdata), .o_ctrl_tlast(ctrl_tlast),
      .o_ctrl_tvalid(ctrl_tvalid), .i_ctrl_tready(ctrl_tready),
      .i_rx_tdata(rx_tdata), .i_rx_tlast(rx_tlast), .i_rx_tvalid(rx_tvalid),
      .o_rx_tready(rx_tready), .i_resp_tdata(resp_tdata), .i_resp_tlast(resp_tlast),
      .i_resp_tvalid(resp_tvalid), .o_resp_tready(resp_tready)
   );

   fx3_slave_model m_i (
      .gpif_clk, .io_gpif_d(gpif_d), .i_sloe(sloe), .i_slrd(slrd), .i_slwr(slwr),
      .i_pktend(pktend), .i_fifoadr(fifoadr), .o_ctl(gpif_ctl)
   );

   always #10 gpif_clk = ~gpif_clk;

   //////////////////////////////
   // LFSR and reference packets
   //////////////////////////////
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr_state[31]};
         lfsr_state = lfsr_next(lfsr_state);
      end
      return r;
   endfunction

   // Word idx of a packet is the 32 bits after 32*idx steps from its seed
   function automatic logic [32:0] ref_word(input logic [31:0] seed, input int idx, input int len);
      logic [31:0] s, w;
      s = seed;
      w = '0;
      repeat (32 * idx) s = lfsr_next(s);
      for (int b = 0; b < 32; b++) begin
         w = {w[30:0], s[31]};
         s = lfsr_next(s);
      end
      return {idx == len - 1, w};
   endfunction

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got == exp) else begin
         errors++;
         $display("Error %s got %h expected %h at %0t", name, got, exp, $time);
      end
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////
   task automatic load_host(input logic [1:0] adr, input logic [31:0] seed, input int len);
      logic [32:0] w;
      for (int i = 0; i < len; i++) begin
         w = ref_word(seed, i, len);
         m_i.push_host(adr, w);
         if (adr == ADDR_DATA_TX) exp_tx.push_back(w);
         else exp_ctrl.push_back(w);
      end
   endtask

   // Drives rx or resp, called at the drive point after an edge
   task automatic send_egress(input logic [1:0] adr, input logic [31:0] seed, input int len);
      logic [32:0] w;
      logic        rdy;
      int          i;
      for (i = 0; i < len; i++) begin
         if (adr == ADDR_DATA_RX) exp_cap1.push_back(ref_word(seed, i, len));
         else exp_cap3.push_back(ref_word(seed, i, len));
      end
      i = 0;
      while (i < len) begin
         w = ref_word(seed, i, len);
         if (adr == ADDR_DATA_RX) {rx_tlast, rx_tdata, rx_tvalid} = {w, 1'b1};
         else {resp_tlast, resp_tdata, resp_tvalid} = {w, 1'b1};
         #1;
         rdy = (adr == ADDR_DATA_RX) ? rx_tready : resp_tready;   // Value at next edge
         @(posedge gpif_clk);
         #2;
         if (rdy) i++;
      end
      if (adr == ADDR_DATA_RX) rx_tvalid = 1'b0;
      else resp_tvalid = 1'b0;
   endtask

   task automatic wait_drained(input int num, input int limit);
      int n;
      n = 0;
      while ((exp_tx.size() + exp_ctrl.size() + exp_cap1.size() + exp_cap3.size()) != 0
             && n < limit) begin
         @(posedge gpif_clk);
         n++;
      end
      repeat (4) @(posedge gpif_clk);
      #2;
      if (n >= limit) begin
         errors++;
         $display("Test %0d timed out with words still outstanding", num);
      end
   endtask

   task automatic finish_test(input int num, input string name, input int err_before);
      $display("test %0d %-26s %s", num, name, (errors == err_before) ? "ok" : "FAILED");
   endtask

   // Random back-pressure on the ingress streams
   always @(posedge gpif_clk) begin : tready_drive
      logic [31:0] bits;
      #2;
      if (rand_tready) begin
         bits = take_bits(2);
         tx_tready   = bits[0];
         ctrl_tready = bits[1];
      end else begin
         tx_tready   = 1'b1;
         ctrl_tready = 1'b1;
      end
   end

   //////////////////////////////
   // Compare, mid cycle
   //////////////////////////////
   always @(negedge gpif_clk) begin : compare
      logic [32:0] e;
      logic        hit;
      if (!gpif_rst) begin
         if (tx_tvalid && tx_tready) begin
            if (exp_tx.size() == 0) begin
               errors++;
               $display("Unexpected word on the tx stream at %0t", $time);
            end else begin
               e = exp_tx.pop_front();
               check_word("o_tx_tdata", tx_tdata, e[31:0]);
               check_word("o_tx_tlast", 32'(tx_tlast), 32'(e[32]));
            end
            if (tx_tlast) tx_pkts++;
         end
         if (ctrl_tvalid && ctrl_tready) begin
            if (exp_ctrl.size() == 0) begin
               errors++;
               $display("Unexpected word on the ctrl stream at %0t", $time);
            end else begin
               e = exp_ctrl.pop_front();
               check_word("o_ctrl_tdata", ctrl_tdata, e[31:0]);
               check_word("o_ctrl_tlast", 32'(ctrl_tlast), 32'(e[32]));
            end
            if (ctrl_tlast) ctrl_pkts++;
         end
         if (!slwr) begin
            hit = 1'b1;
            if (fifoadr == ADDR_DATA_RX && exp_cap1.size() != 0) begin
               e = exp_cap1.pop_front();
            end else if (fifoadr == ADDR_CTRL_RX && exp_cap3.size() != 0) begin
               e = exp_cap3.pop_front();
            end else begin
               hit = 1'b0;
               errors++;
               $display("Unexpected bus write at address %0d at %0t", fifoadr, $time);
            end
            if (hit) begin
               check_word("io_gpif_d", gpif_d, e[31:0]);
               check_word("o_pktend", 32'(!pktend), 32'(e[32]));   // Only on the last word
            end
         end else if (!pktend) begin
            errors++;
            $display("Packet end strobe without a write at %0t", $time);
         end
      end
   end

   // Watchdog
   initial begin
      repeat (40 * MAX_WORDS + 2000) @(posedge gpif_clk);
      $display("Watchdog expired before the tests finished");
      $display("SIMULATION FAILED");
      $finish;
   end

   //////////////////////////////
   // Test sequence
   //////////////////////////////
   initial begin : main
      int          eb, c1, c3, ct, cc;
      logic [31:0] sa, sb, sc, sd;
      gpif_clk = 1'b0;
      gpif_rst = 1'b1;
      gpif_enb = 1'b1;
      tx_tready = 1'b1;
      ctrl_tready = 1'b1;
      {rx_tdata, rx_tlast, rx_tvalid} = '0;
      {resp_tdata, resp_tlast, resp_tvalid} = '0;
      lfsr_state = 32'h0e09_777e;
      rand_tready = 1'b0;
      {errors, checks, tx_pkts, ctrl_pkts} = '0;
      repeat (16) @(posedge gpif_clk);
      #2;
      gpif_rst = 1'b0;

      // 1: idle strobes
      eb = errors;
      @(posedge gpif_clk);
      #2;
      check_word("o_slrd", 32'(slrd), 32'd1);
      check_word("o_slwr", 32'(slwr), 32'd1);
      check_word("o_pktend", 32'(pktend), 32'd1);
      check_word("o_sloe", 32'(sloe), 32'd0);
      finish_test(1, "idle after reset", eb);

      // 2: host data packet
      eb = errors;
      load_host(ADDR_DATA_TX, take_bits(32) | 32'd1, 4 + int'(take_bits(6)) % 61);
      wait_drained(2, 4000);
      finish_test(2, "host data to tx", eb);

      // 3: host control packet
      eb = errors;
      load_host(ADDR_CTRL_TX, take_bits(32) | 32'd1, 4 + int'(take_bits(3)) % 5);
      wait_drained(3, 2000);
      finish_test(3, "host control to ctrl", eb);

      // 4: rx and resp to the host
      eb = errors;
      c1 = m_i.pkt_cnt[1];
      c3 = m_i.pkt_cnt[3];
      sa = take_bits(32) | 32'd1;
      sb = take_bits(32) | 32'd1;
      fork
         send_egress(ADDR_DATA_RX, sa, 4 + int'(take_bits(6)) % 61);
         send_egress(ADDR_CTRL_RX, sb, 4 + int'(take_bits(3)) % 5);
      join
      wait_drained(4, 4000);
      check_word("pkt_cnt[1]", 32'(m_i.pkt_cnt[1]), 32'(c1 + 1));
      check_word("pkt_cnt[3]", 32'(m_i.pkt_cnt[3]), 32'(c3 + 1));
      finish_test(4, "rx and resp to host", eb);

      // 5: back to back with back-pressure
      eb = errors;
      ct = tx_pkts;
      for (int p = 0; p < 3; p++) begin
         load_host(ADDR_DATA_TX, take_bits(32) | 32'd1, 4 + int'(take_bits(6)) % 61);
      end
      rand_tready = 1'b1;
      wait_drained(5, 12000);
      rand_tready = 1'b0;
      check_word("tx packets", 32'(tx_pkts), 32'(ct + 3));
      finish_test(5, "back-pressure on streams", eb);

      // 6: all four endpoints busy
      eb = errors;
      {c1, c3, ct, cc} = {m_i.pkt_cnt[1], m_i.pkt_cnt[3], tx_pkts, ctrl_pkts};
      {sa, sb, sc, sd} = {take_bits(32) | 32'd1, take_bits(32) | 32'd1,
                          take_bits(32) | 32'd1, take_bits(32) | 32'd1};
      load_host(ADDR_DATA_TX, sa, 64);
      load_host(ADDR_CTRL_TX, sb, 8);
      fork
         send_egress(ADDR_DATA_RX, sc, 64);
         send_egress(ADDR_CTRL_RX, sd, 8);
      join
      wait_drained(6, 8000);
      check_word("tx packets", 32'(tx_pkts), 32'(ct + 1));
      check_word("ctrl packets", 32'(ctrl_pkts), 32'(cc + 1));
      check_word("pkt_cnt[1]", 32'(m_i.pkt_cnt[1]), 32'(c1 + 1));
      check_word("pkt_cnt[3]", 32'(m_i.pkt_cnt[3]), 32'(c3 + 1));
      finish_test(6, "all endpoints at once", eb);

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

//--- gpif_slave_fifo32.f
gpif_pkg.sv
gpif_stream_if.sv
gpif_stream_fifo.sv
gpif_addr_arbiter.sv
gpif_bus_master.sv
gpif_slave_fifo32.sv
fx3_slave_model.sv
tb_gpif_slave_fifo32.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, fail if the log reports failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_gpif_slave_fifo32 -f gpif_slave_fifo32.f -o sim_gpif > build.log 2>&1 \
   && ./obj_dir/sim_gpif > sim.log 2>&1 \
   || { cat build.log; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0
